// File: logic/mips_defs.svh
// core-wide width, register count, data-memory address and reset-vector defines
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// ==========================================================================
// datapath sizing
// ==========================================================================

// data and instruction word width
`define MIPS_XLEN 32

// architectural registers, r0 hard-wired to zero
`define MIPS_NREGS 32

// data memory is word addressed, 128 words
`define MIPS_DMEM_AW 7

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// File: logic/mipsIsaPkg.sv
// instruction-set types: word, register number, opcode/funct encodings, fields
`include "mips_defs.svh"

package mipsIsaPkg;

  // one data or instruction word
  typedef logic [`MIPS_XLEN-1:0] word_t;

  // register number, rs/rt/rd fields
  typedef logic [4:0] regAddr_t;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_t;

  // R-type function code, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL = 6'h00,
    FN_SRL = 6'h02,
    FN_JR  = 6'h08,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_t;

  // raw I-type immediate before extension
  typedef logic [15:0] imm16_t;

  // J-type target index, word granular
  typedef logic [25:0] jIndex_t;

  // shift amount for sll/srl
  typedef logic [4:0] shamt_t;

endpackage

// File: logic/mipsCtrlPkg.sv
// control types: ALU operation select and writeback source select
package mipsCtrlPkg;

  // ==========================================================================
  // ALU operation
  // ==========================================================================

  // add also serves lw/sw address generation
  // sub also serves the beq compare
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6
  } aluOp_t;

  // ==========================================================================
  // writeback source
  // ==========================================================================

  // link is the return address for jal
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_MEM  = 2'd1,
    WB_LINK = 2'd2
  } wbSel_t;

endpackage

// File: logic/decodeIf.sv
// decodeIf interface: decoded instruction fields and control, decoder to datapath
`timescale 1ns/1ns

interface decodeIf;
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;

  // register numbers, rd already resolved (rd, rt or r31)
  regAddr_t rs;
  regAddr_t rt;
  regAddr_t rd;

  // operand fields
  word_t    immExt;
  shamt_t   shamt;
  jIndex_t  jIndex;

  // control
  logic     regWrite;
  logic     aluSrcImm;
  logic     memRead;
  logic     memWrite;
  logic     branch;
  logic     jump;
  logic     jumpReg;
  aluOp_t   aluOp;
  wbSel_t   wbSel;

  // decoder side
  modport producer (output rs, rt, rd, immExt, shamt, jIndex, regWrite, aluSrcImm,
                    memRead, memWrite, branch, jump, jumpReg, aluOp, wbSel);

  // datapath side
  modport consumer (input rs, rt, rd, immExt, shamt, jIndex, regWrite, aluSrcImm,
                    memRead, memWrite, branch, jump, jumpReg, aluOp, wbSel);

endinterface

// File: logic/fetchUnit.sv
// fetchUnit: program counter and next-address selection
`timescale 1ns/1ns
`include "mips_defs.svh"

module fetchUnit (
  input  logic               clk,
  input  logic               rst,
  decodeIf.consumer          dec,
  input  logic               aluZero,
  input  mipsIsaPkg::word_t  rsData,
  output mipsIsaPkg::word_t  pc,
  output mipsIsaPkg::word_t  pcPlus4
);
  import mipsIsaPkg::*;

  word_t pcNext;
  word_t branchTarget;
  word_t jumpTarget;

  // sequential address, also the jal link value
  assign pcPlus4 = pc + word_t'(4);

  // branch offset counts words relative to pc+4
  assign branchTarget = pcPlus4 + {dec.immExt[`MIPS_XLEN-3:0], 2'b00};

  // j/jal stay inside the current 256MB region
  assign jumpTarget = {pcPlus4[`MIPS_XLEN-1:28], dec.jIndex, 2'b00};

  // jr first, then j/jal, then taken beq
  always_comb begin
    if (dec.jumpReg) begin
      pcNext = rsData;
    end else if (dec.jump) begin
      pcNext = jumpTarget;
    end else if (dec.branch && aluZero) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // one instruction retired per edge
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

  // jr targets come from the register file, so alignment is software's job
  pcAligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("fetch address not word aligned: %h", pc);

endmodule

// File: logic/instrDecoder.sv
// instrDecoder: main and ALU control decode, immediate extension, destination select
`timescale 1ns/1ns
`include "mips_defs.svh"

module instrDecoder (
  input  mipsIsaPkg::word_t  instr,
  decodeIf.producer          dec
);
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;

  imm16_t   imm;
  regAddr_t rdField;

  // ==========================================================================
  // field extraction
  // ==========================================================================

  assign imm     = instr[15:0];
  assign rdField = instr[15:11];

  assign dec.rs     = instr[25:21];
  assign dec.rt     = instr[20:16];
  assign dec.shamt  = instr[10:6];
  assign dec.jIndex = instr[25:0];

  // sign extension for lw/sw offsets and beq displacement
  assign dec.immExt = {{(`MIPS_XLEN-16){imm[15]}}, imm};

  // ==========================================================================
  // control decode
  // ==========================================================================

  always_comb begin
    // defaults describe a no-op, so unknown encodings fall through harmlessly
    dec.rd        = '0;
    dec.regWrite  = 1'b0;
    dec.aluSrcImm = 1'b0;
    dec.memRead   = 1'b0;
    dec.memWrite  = 1'b0;
    dec.branch    = 1'b0;
    dec.jump      = 1'b0;
    dec.jumpReg   = 1'b0;
    dec.aluOp     = ALU_ADD;
    dec.wbSel     = WB_ALU;

    case (instr[31:26])
      OP_RTYPE: begin
        dec.rd = rdField;
        // funct picks the ALU op; jr only redirects fetch
        case (instr[5:0])
          FN_ADD: begin dec.regWrite = 1'b1; dec.aluOp = ALU_ADD; end
          FN_SUB: begin dec.regWrite = 1'b1; dec.aluOp = ALU_SUB; end
          FN_AND: begin dec.regWrite = 1'b1; dec.aluOp = ALU_AND; end
          FN_OR:  begin dec.regWrite = 1'b1; dec.aluOp = ALU_OR;  end
          FN_SLT: begin dec.regWrite = 1'b1; dec.aluOp = ALU_SLT; end
          FN_SLL: begin dec.regWrite = 1'b1; dec.aluOp = ALU_SLL; end
          FN_SRL: begin dec.regWrite = 1'b1; dec.aluOp = ALU_SRL; end
          FN_JR:  dec.jumpReg = 1'b1;
          default: ;
        endcase
      end
      OP_LW: begin
        // address = rs + offset, data lands in rt
        dec.rd        = dec.rt;
        dec.regWrite  = 1'b1;
        dec.aluSrcImm = 1'b1;
        dec.memRead   = 1'b1;
        dec.wbSel     = WB_MEM;
      end
      OP_SW: begin
        dec.aluSrcImm = 1'b1;
        dec.memWrite  = 1'b1;
      end
      OP_BEQ: begin
        // rs - rt, zero flag decides
        dec.branch = 1'b1;
        dec.aluOp  = ALU_SUB;
      end
      OP_J: dec.jump = 1'b1;
      OP_JAL: begin
        // return address into r31, no delay slot
        dec.rd       = regAddr_t'(`MIPS_NREGS - 1);
        dec.regWrite = 1'b1;
        dec.jump     = 1'b1;
        dec.wbSel    = WB_LINK;
      end
      default: ;
    endcase
  end

endmodule

// File: logic/regFile.sv
// regFile: 32x32 register file, two combinational reads, one clocked write
`timescale 1ns/1ns
`include "mips_defs.svh"

module regFile (
  input  logic               clk,
  input  logic               rst,
  decodeIf.consumer          dec,
  input  logic               wrEn,
  input  mipsIsaPkg::word_t  wrData,
  output mipsIsaPkg::word_t  rsData,
  output mipsIsaPkg::word_t  rtData
);
  import mipsIsaPkg::*;

  word_t regs [`MIPS_NREGS];

  // ==========================================================================
  // write port
  // ==========================================================================

  // architectural state, cleared on reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `MIPS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (dec.rd != '0)) begin
      // r0 never takes a write
      regs[dec.rd] <= wrData;
    end
  end

  // ==========================================================================
  // read ports
  // ==========================================================================

  // r0 reads as zero regardless of array content
  assign rsData = (dec.rs == '0) ? '0 : regs[dec.rs];
  assign rtData = (dec.rt == '0) ? '0 : regs[dec.rt];

  // writeback value comes from ALU, memory or link path
  wrDataKnown: assert property (@(posedge clk) disable iff (!rst)
                                wrEn |-> !$isunknown(wrData))
    else $error("register write with unknown data to r%0d", dec.rd);

endmodule

// File: logic/aluUnit.sv
// aluUnit: operand B select, arithmetic/logic/shift ops and zero flag
`timescale 1ns/1ns

module aluUnit (
  decodeIf.consumer          dec,
  input  mipsIsaPkg::word_t  rsData,
  input  mipsIsaPkg::word_t  rtData,
  output mipsIsaPkg::word_t  result,
  output logic               zero
);
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;

  word_t opB;
  logic  lessThan;

  // immediate for lw/sw, register otherwise
  assign opB = dec.aluSrcImm ? dec.immExt : rtData;

  // slt is a signed compare
  assign lessThan = $signed(rsData) < $signed(opB);

  always_comb begin
    case (dec.aluOp)
      ALU_ADD: result = rsData + opB;
      ALU_SUB: result = rsData - opB;
      ALU_AND: result = rsData & opB;
      ALU_OR:  result = rsData | opB;
      ALU_SLT: result = word_t'(lessThan);
      // shifts act on rt, amount from the shamt field
      ALU_SLL: result = rtData << dec.shamt;
      ALU_SRL: result = rtData >> dec.shamt;
      default: result = '0;
    endcase
  end

  // beq takes the branch on equal operands
  assign zero = (result == '0);

endmodule

// File: logic/memWriteback.sv
// memWriteback: data-memory port drive, writeback value select and strobe
`timescale 1ns/1ns
`include "mips_defs.svh"

module memWriteback (
  decodeIf.consumer                  dec,
  input  mipsIsaPkg::word_t          aluResult,
  input  mipsIsaPkg::word_t          rtData,
  input  mipsIsaPkg::word_t          pcPlus4,
  input  mipsIsaPkg::word_t          dmemRdata,
  output logic                       dmemCen,
  output logic                       dmemWen,
  output logic                       dmemOen,
  output logic [`MIPS_DMEM_AW-1:0]   dmemAddr,
  output mipsIsaPkg::word_t          dmemWdata,
  output logic                       wrEn,
  output logic                       wbValid,
  output mipsIsaPkg::regAddr_t       wbReg,
  output mipsIsaPkg::word_t          wbData
);
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;

  // ==========================================================================
  // data memory port
  // ==========================================================================

  // active-low enables, chip selected only for lw/sw
  assign dmemCen   = !(dec.memRead || dec.memWrite);
  assign dmemWen   = !dec.memWrite;
  // outputs always enabled, read data is muxed by wbSel
  assign dmemOen   = 1'b0;
  // byte address to word address
  assign dmemAddr  = aluResult[`MIPS_DMEM_AW+1:2];
  assign dmemWdata = rtData;

  // ==========================================================================
  // writeback
  // ==========================================================================

  always_comb begin
    case (dec.wbSel)
      WB_MEM:  wbData = dmemRdata;
      WB_LINK: wbData = pcPlus4;
      default: wbData = aluResult;
    endcase
  end

  // writes to r0 are suppressed, no strobe either
  assign wrEn    = dec.regWrite && (dec.rd != '0);
  assign wbValid = wrEn;
  assign wbReg   = dec.rd;

  // a decoded instruction is never both load and store
  always_comb begin
    rdWrExclusive: assert #0 (!(!dmemCen && !dmemWen && dec.memRead))
      else $error("data memory write enabled during a load");
  end

endmodule

// File: logic/mipsCore.sv
// mipsCore: single-cycle core top level connecting fetch, decode, datapath, memory
`timescale 1ns/1ns
`include "mips_defs.svh"

module mipsCore (
  input  logic                       clk,
  input  logic                       rst,
  // instruction memory
  output mipsIsaPkg::word_t          instrAddr,
  input  mipsIsaPkg::word_t          instr,
  // data memory, enables active low
  output logic                       dmemCen,
  output logic                       dmemWen,
  output logic                       dmemOen,
  output logic [`MIPS_DMEM_AW-1:0]   dmemAddr,
  output mipsIsaPkg::word_t          dmemWdata,
  input  mipsIsaPkg::word_t          dmemRdata,
  // register writeback observation
  output logic                       wbValid,
  output mipsIsaPkg::regAddr_t       wbReg,
  output mipsIsaPkg::word_t          wbData
);
  import mipsIsaPkg::*;

  word_t pcPlus4;
  word_t rsData;
  word_t rtData;
  word_t aluResult;
  logic  aluZero;
  logic  wrEn;

  decodeIf dec ();

  // ==========================================================================
  // input side
  // ==========================================================================

  fetchUnit fetch_i (
    .clk(clk), .rst(rst), .dec(dec), .aluZero(aluZero), .rsData(rsData),
    .pc(instrAddr), .pcPlus4(pcPlus4)
  );

  instrDecoder decode_i (.instr(instr), .dec(dec));

  // ==========================================================================
  // processing
  // ==========================================================================

  // writeback value feeds the write port directly
  regFile regs_i (
    .clk(clk), .rst(rst), .dec(dec), .wrEn(wrEn), .wrData(wbData),
    .rsData(rsData), .rtData(rtData)
  );

  aluUnit alu_i (
    .dec(dec), .rsData(rsData), .rtData(rtData), .result(aluResult), .zero(aluZero)
  );

  // ==========================================================================
  // output side
  // ==========================================================================

  memWriteback memWb_i (
    .dec(dec), .aluResult(aluResult), .rtData(rtData), .pcPlus4(pcPlus4),
    .dmemRdata(dmemRdata), .dmemCen(dmemCen), .dmemWen(dmemWen), .dmemOen(dmemOen),
    .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .wrEn(wrEn), .wbValid(wbValid),
    .wbReg(wbReg), .wbData(wbData)
  );

endmodule

// File: tb/clkGen.sv
// clkGen: testbench clock source and active-low reset sequencer
`timescale 1ns/1ns

module clkGen #(
  parameter int halfPeriod  = 20,
  parameter int resetCycles = 8
) (
  output logic clk,
  output logic rst
);

  // free-running clock, 40 ns period by default
  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  // reset held low, released on a rising edge
  initial begin
    rst = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b1;
  end

endmodule

// File: tb/mipsCoreTb.sv
// mipsCoreTb: memory models, program table, reference model, checks and report
`timescale 1ns/1ns
`include "mips_defs.svh"

module mipsCoreTb;
  import mipsIsaPkg::*;

  localparam int progLen     = 30;
  localparam int resetCycles = 8;
  localparam int cycleLimit  = progLen + resetCycles + 16;
  localparam int dmemWords   = 1 << `MIPS_DMEM_AW;
  localparam int numTests    = 6;

  // encodings, written out from the ISA
  localparam logic [5:0] opLw  = 6'h23;
  localparam logic [5:0] opSw  = 6'h2b;
  localparam logic [5:0] opBeq = 6'h04;
  localparam logic [5:0] opJ   = 6'h02;
  localparam logic [5:0] opJal = 6'h03;
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;
  localparam logic [5:0] fnSll = 6'h00;
  localparam logic [5:0] fnSrl = 6'h02;
  localparam logic [5:0] fnJr  = 6'h08;

  logic                     clk;
  logic                     rst;
  word_t                    instrAddr;
  word_t                    instr;
  logic                     dmemCen;
  logic                     dmemWen;
  logic                     dmemOen;
  logic [`MIPS_DMEM_AW-1:0] dmemAddr;
  word_t                    dmemWdata;
  word_t                    dmemRdata;
  logic                     wbValid;
  regAddr_t                 wbReg;
  word_t                    wbData;

  // program table: instruction, expected strobe register (0 = none), test number
  word_t    progInstr  [progLen];
  regAddr_t progExpReg [progLen];
  int       progTest   [progLen];
  int       progCount;

  word_t    dmem [dmemWords];
  logic [31:0] lfsrState;

  // reference model state and this cycle's expectations
  word_t    mReg [`MIPS_NREGS];
  word_t    mMem [dmemWords];
  word_t    mPc;
  logic     eCen;
  logic     eWen;
  logic [`MIPS_DMEM_AW-1:0] eAddr;
  word_t    eWdata;
  word_t    eData;
  word_t    nPc;
  regAddr_t dstReg;
  logic     memWrite;

  int    curTest;
  int    checks [1:numTests];
  int    errs [1:numTests];
  string testName [1:numTests];
  int    cycleCount;

  clkGen #(.halfPeriod(20), .resetCycles(resetCycles)) clkGen_i (.clk(clk), .rst(rst));

  mipsCore dut_i (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .dmemCen(dmemCen), .dmemWen(dmemWen), .dmemOen(dmemOen), .dmemAddr(dmemAddr),
    .dmemWdata(dmemWdata), .dmemRdata(dmemRdata),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  // ==========================================================================
  // memory models
  // ==========================================================================

  // past the table the fetch sees nops
  assign instr     = (instrAddr[31:2] < progLen) ? progInstr[instrAddr[31:2]] : '0;
  assign dmemRdata = dmem[dmemAddr];

  always @(posedge clk) begin
    if (!dmemCen && !dmemWen) begin
      dmem[dmemAddr] <= dmemWdata;
    end
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  // right-shift Galois LFSR, taps x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one LFSR step per data bit
  task automatic drawWord(output word_t w);
    for (int b = 0; b < 32; b++) begin
      w[b] = lfsrState[0];
      lfsrState = lfsrStep(lfsrState);
    end
  endtask

  function automatic word_t encR(input logic [4:0] rs, input logic [4:0] rt,
                                 input logic [4:0] rd, input logic [4:0] sh,
                                 input logic [5:0] fn);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t encI(input logic [5:0] op, input logic [4:0] rs,
                                 input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t encJ(input logic [5:0] op, input logic [25:0] idx);
    return {op, idx};
  endfunction

  task automatic addProg(input word_t iw, input regAddr_t expReg, input int testId);
    progInstr[progCount]  = iw;
    progExpReg[progCount] = expReg;
    progTest[progCount]   = testId;
    progCount++;
  endtask

  task automatic buildProgram();
    progCount = 0;
    // 0: nop, keeps the reset-time outputs quiet
    addProg(encR(5'd0, 5'd0, 5'd0, 5'd0, fnSll), 5'd0, 1);
    // 1-8: seeded operands, then every ALU op
    addProg(encI(opLw, 5'd0, 5'd1, 16'd0), 5'd1, 2);
    addProg(encI(opLw, 5'd0, 5'd2, 16'd4), 5'd2, 2);
    addProg(encR(5'd1, 5'd2, 5'd3, 5'd0, fnAdd), 5'd3, 2);
    addProg(encR(5'd1, 5'd2, 5'd4, 5'd0, fnSub), 5'd4, 2);
    addProg(encR(5'd1, 5'd2, 5'd5, 5'd0, fnAnd), 5'd5, 2);
    addProg(encR(5'd1, 5'd2, 5'd6, 5'd0, fnOr), 5'd6, 2);
    addProg(encR(5'd1, 5'd2, 5'd7, 5'd0, fnSlt), 5'd7, 2);
    addProg(encR(5'd2, 5'd1, 5'd8, 5'd0, fnSlt), 5'd8, 2);
    // 9-12: shifts, a write to r0, then r0 as a source
    addProg(encR(5'd0, 5'd1, 5'd9, 5'd4, fnSll), 5'd9, 3);
    addProg(encR(5'd0, 5'd1, 5'd10, 5'd7, fnSrl), 5'd10, 3);
    addProg(encR(5'd0, 5'd1, 5'd0, 5'd3, fnSll), 5'd0, 3);
    addProg(encR(5'd0, 5'd1, 5'd11, 5'd0, fnAdd), 5'd11, 3);
    // 13-16: store and reload
    addProg(encI(opSw, 5'd0, 5'd3, 16'd16), 5'd0, 4);
    addProg(encI(opLw, 5'd0, 5'd12, 16'd16), 5'd12, 4);
    addProg(encI(opSw, 5'd0, 5'd6, 16'd40), 5'd0, 4);
    addProg(encI(opLw, 5'd0, 5'd13, 16'd40), 5'd13, 4);
    // 17-26: control flow, 18 and 21 are skipped
    addProg(encI(opBeq, 5'd1, 5'd11, 16'd1), 5'd0, 5);
    addProg(encR(5'd1, 5'd1, 5'd14, 5'd0, fnAdd), 5'd14, 5);
    addProg(encI(opBeq, 5'd1, 5'd2, 16'd5), 5'd0, 5);
    addProg(encJ(opJ, 26'd22), 5'd0, 5);
    addProg(encR(5'd1, 5'd1, 5'd15, 5'd0, fnAdd), 5'd15, 5);
    addProg(encJ(opJal, 26'd25), 5'd31, 5);
    // jr lands here
    addProg(encR(5'd31, 5'd0, 5'd16, 5'd0, fnAdd), 5'd16, 5);
    addProg(encJ(opJ, 26'd27), 5'd0, 5);
    addProg(encR(5'd1, 5'd2, 5'd17, 5'd0, fnAdd), 5'd17, 5);
    addProg(encR(5'd31, 5'd0, 5'd0, 5'd0, fnJr), 5'd0, 5);
    // 27-29: bad opcode, bad funct, then read back r1/r2
    addProg(encI(6'h3f, 5'd1, 5'd2, 16'h0010), 5'd0, 6);
    addProg(encR(5'd1, 5'd2, 5'd18, 5'd0, 6'h3f), 5'd0, 6);
    addProg(encR(5'd1, 5'd2, 5'd18, 5'd0, fnOr), 5'd18, 6);
  endtask

  // ==========================================================================
  // reference model
  // ==========================================================================

  task automatic predict(input word_t iw);
    word_t a;
    word_t b;
    word_t imm;
    word_t pc4;
    word_t ea;
    a   = mReg[iw[25:21]];
    b   = mReg[iw[20:16]];
    imm = {{16{iw[15]}}, iw[15:0]};
    pc4 = mPc + 32'd4;
    ea  = a + imm;
    eCen     = 1'b1;
    eWen     = 1'b1;
    eAddr    = '0;
    eWdata   = '0;
    eData    = '0;
    nPc      = pc4;
    dstReg   = '0;
    memWrite = 1'b0;
    case (iw[31:26])
      6'h00: begin
        dstReg = iw[15:11];
        case (iw[5:0])
          fnAdd: eData = a + b;
          fnSub: eData = a - b;
          fnAnd: eData = a & b;
          fnOr:  eData = a | b;
          fnSlt: eData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          fnSll: eData = b << iw[10:6];
          fnSrl: eData = b >> iw[10:6];
          fnJr: begin
            nPc    = a;
            dstReg = '0;
          end
          default: dstReg = '0;
        endcase
      end
      opLw: begin
        eCen   = 1'b0;
        eAddr  = ea[`MIPS_DMEM_AW+1:2];
        eData  = mMem[eAddr];
        dstReg = iw[20:16];
      end
      opSw: begin
        eCen     = 1'b0;
        eWen     = 1'b0;
        eAddr    = ea[`MIPS_DMEM_AW+1:2];
        eWdata   = b;
        memWrite = 1'b1;
      end
      opBeq: begin
        if (a == b) begin
          nPc = pc4 + (imm << 2);
        end
      end
      opJ: nPc = {pc4[31:28], iw[25:0], 2'b00};
      opJal: begin
        nPc    = {pc4[31:28], iw[25:0], 2'b00};
        dstReg = 5'd31;
        eData  = pc4;
      end
      default: ;
    endcase
  endtask

  task automatic retire();
    if (dstReg != '0) begin
      mReg[dstReg] = eData;
    end
    if (memWrite) begin
      mMem[eAddr] = eWdata;
    end
    mPc = nPc;
  endtask

  // ==========================================================================
  // checks and report
  // ==========================================================================

  task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    checks[curTest]++;
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errs[curTest]++;
    end
  endtask

  // strobe expectation comes from the table, data from the model
  task automatic checkCycle(input regAddr_t expReg);
    checkValue(instrAddr, mPc, "instrAddr");
    checkValue(wbValid, expReg != '0, $sformatf("wbValid at pc %h", mPc));
    if (expReg != '0) begin
      checkValue(wbReg, expReg, $sformatf("wbReg at pc %h", mPc));
      checkValue(wbData, eData, $sformatf("wbData at pc %h", mPc));
    end
    checkValue(dmemCen, eCen, $sformatf("dmemCen at pc %h", mPc));
    checkValue(dmemWen, eWen, $sformatf("dmemWen at pc %h", mPc));
    if (!eCen) begin
      checkValue(dmemAddr, eAddr, $sformatf("dmemAddr at pc %h", mPc));
    end
    if (!eWen) begin
      checkValue(dmemWdata, eWdata, $sformatf("dmemWdata at pc %h", mPc));
    end
  endtask

  task automatic reportTest(input int t);
    if (errs[t] == 0) begin
      $display("test %0d, %s: pass, %0d checks", t, testName[t], checks[t]);
    end else begin
      $display("test %0d, %s: fail, %0d of %0d checks wrong", t, testName[t],
               errs[t], checks[t]);
    end
  endtask

  initial begin : mainSeq
    word_t seedWord;
    int    idx;
    int    totalChecks;
    int    totalErrs;
    int    failedTests;
    testName[1] = "reset and first fetch";
    testName[2] = "R-type ALU on loaded data";
    testName[3] = "shifts and r0 writes";
    testName[4] = "store then load";
    testName[5] = "branch and jump flow";
    testName[6] = "unknown encodings";
    for (int t = 1; t <= numTests; t++) begin
      checks[t] = 0;
      errs[t]   = 0;
    end
    buildProgram();
    // seed data memory and its shadow before reset ends
    lfsrState = 32'h9341_30d2;
    for (int i = 0; i < dmemWords; i++) begin
      drawWord(seedWord);
      dmem[i] = seedWord;
      mMem[i] = seedWord;
    end
    for (int r = 0; r < `MIPS_NREGS; r++) begin
      mReg[r] = '0;
    end
    mPc     = `MIPS_RESET_PC;
    curTest = 1;

    // outputs sampled mid-cycle, away from the edge
    @(negedge clk);
    while (!rst) begin
      checkValue(instrAddr, `MIPS_RESET_PC, "instrAddr during reset");
      checkValue(wbValid, 1'b0, "wbValid during reset");
      checkValue(dmemCen, 1'b1, "dmemCen during reset");
      checkValue(dmemWen, 1'b1, "dmemWen during reset");
      checkValue(dmemOen, 1'b0, "dmemOen during reset");
      @(negedge clk);
    end

    // follow the model pc until it leaves the table
    while (mPc[31:2] < progLen) begin
      idx = mPc[31:2];
      if (progTest[idx] != curTest) begin
        reportTest(curTest);
        curTest = progTest[idx];
      end
      predict(progInstr[idx]);
      checkCycle(progExpReg[idx]);
      retire();
      @(negedge clk);
    end

    // whole memory against the shadow, catches stray writes
    for (int i = 0; i < dmemWords; i++) begin
      checkValue(dmem[i], mMem[i], $sformatf("dmem word %0d", i));
    end
    reportTest(curTest);

    totalChecks = 0;
    totalErrs   = 0;
    failedTests = 0;
    for (int t = 1; t <= numTests; t++) begin
      totalChecks += checks[t];
      totalErrs   += errs[t];
      if (errs[t] != 0) begin
        failedTests++;
      end
    end
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", numTests,
             failedTests, totalChecks, totalErrs);
    if (totalErrs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // limit covers reset plus at most one pass through the table
  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("ERROR: program did not finish within %0d cycles", cycleLimit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: flist.f
+incdir+logic
logic/mipsIsaPkg.sv
logic/mipsCtrlPkg.sv
logic/decodeIf.sv
logic/fetchUnit.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/aluUnit.sv
logic/memWriteback.sv
logic/mipsCore.sv
tb/clkGen.sv
tb/mipsCoreTb.sv

// File: Bender.yml
package:
  name: mips_core

export_include_dirs:
  - logic

sources:
  - logic/mipsIsaPkg.sv
  - logic/mipsCtrlPkg.sv
  - logic/decodeIf.sv
  - logic/fetchUnit.sv
  - logic/instrDecoder.sv
  - logic/regFile.sv
  - logic/aluUnit.sv
  - logic/memWriteback.sv
  - logic/mipsCore.sv
  - target: test
    files:
      - tb/clkGen.sv
      - tb/mipsCoreTb.sv
